//--- Bender.yml
package:
  name: pmp_unit

export_include_dirs:
  - .

sources:
  - files:
      - pmp_pkg.sv
      - pmp_csr_decode.sv
      - pmp_csr_file.sv
      - pmp_check.sv
      - pmp_top.sv
  - target: test
    files:
      - tb_pmp_top.sv

//--- filelist.f
+incdir+.
pmp_pkg.sv
pmp_csr_decode.sv
pmp_csr_file.sv
pmp_check.sv
pmp_top.sv
tb_pmp_top.sv

//--- pmp_check.sv
`timescale 1ns/1ps
`include "pmp_defines.svh"

module pmp_check (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  pmp_pkg::acc_req_t   req_i,
  input  pmp_pkg::pmp_state_t state_i,
  output logic                done_o,
  output logic                fault_o
);
  import pmp_pkg::*;

  logic [31:0]                        addr_w;
  logic [`PMP_NUM_REGIONS-1:0][31:0]  tor_base;
  logic [`PMP_NUM_REGIONS-1:0][31:0]  napot_mask;
  logic [`PMP_NUM_REGIONS-1:0]        region_match;
  logic                               hit;
  pmp_cfg_t                           hit_cfg;
  logic                               type_ok;
  logic                               allowed;
  logic                               done_q;
  logic                               fault_q;

  // Word address, same scale as pmpaddr
  assign addr_w = {2'b00, req_i.addr[31:2]};

  // Region 0 TOR starts at zero
  assign tor_base = {state_i.addr[`PMP_NUM_REGIONS-2:0], 32'd0};

  always_comb begin
    for (int i = 0; i < `PMP_NUM_REGIONS; i++) begin
      // Trailing ones plus the next zero are don't care
      napot_mask[i] = ~(state_i.addr[i] ^ (state_i.addr[i] + 32'd1));
      case (state_i.cfg[i].mode)
        PMP_MODE_TOR: begin
          region_match[i] = (addr_w >= tor_base[i]) && (addr_w < state_i.addr[i]);
        end
        PMP_MODE_NA4: begin
          region_match[i] = (addr_w == state_i.addr[i]);
        end
        PMP_MODE_NAPOT: begin
          region_match[i] = ((addr_w & napot_mask[i]) ==
                             (state_i.addr[i] & napot_mask[i]));
        end
        default: begin
          region_match[i] = 1'b0;
        end
      endcase
    end
  end

  // Lowest matching region wins
  always_comb begin
    hit     = 1'b0;
    hit_cfg = '0;
    for (int i = `PMP_NUM_REGIONS - 1; i >= 0; i--) begin
      if (region_match[i]) begin
        hit     = 1'b1;
        hit_cfg = state_i.cfg[i];
      end
    end
  end

  always_comb begin
    case (req_i.acc_type)
      ACC_EXEC:  type_ok = hit_cfg.exec;
      ACC_READ:  type_ok = hit_cfg.read;
      ACC_WRITE: type_ok = hit_cfg.write;
      default:   type_ok = 1'b0;
    endcase
  end

  always_comb begin
    if (!hit) begin
      allowed = (req_i.priv == PRIV_M);
    end else if (req_i.priv == PRIV_M) begin
      // M-mode only bound by locked entries
      allowed = !hit_cfg.lock || type_ok;
    end else begin
      allowed = type_ok;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      done_q  <= 1'b0;
      fault_q <= 1'b0;
    end else begin
      done_q  <= req_i.valid;
      fault_q <= req_i.valid && !allowed;
    end
  end

  assign done_o  = done_q;
  assign fault_o = fault_q;

endmodule

//--- pmp_csr_decode.sv
`timescale 1ns/1ps
`include "pmp_defines.svh"

module pmp_csr_decode (
  input  logic             csr_valid_i,
  input  logic [31:0]      insn_i,
  input  logic [31:0]      rs1_data_i,
  input  pmp_pkg::priv_e   priv_i,
  output pmp_pkg::csr_op_t op_o
);
  import pmp_pkg::*;

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [4:0]  rs1_addr;
  logic [11:0] csr_num;
  logic [11:0] addr_off;
  logic        is_csr_insn;
  logic        is_imm;
  logic        in_pmp_space;
  logic        is_known;
  csr_sel_e    sel;
  csr_cmd_e    cmd;

  assign opcode   = insn_i[6:0];
  assign funct3   = insn_i[14:12];
  assign rs1_addr = insn_i[19:15];
  assign csr_num  = insn_i[31:20];

  // funct3 of 000 and 100 are not CSR accesses
  assign is_csr_insn = (opcode == `PMP_OPC_SYSTEM) && (funct3[1:0] != 2'b00);
  assign is_imm      = funct3[2];

  // Offset into the pmpaddr block, wraps high below the base
  assign addr_off = csr_num - `PMP_CSR_PMPADDR0;

  // Whole PMP CSR space, implemented or not
  assign in_pmp_space = (csr_num inside {[`PMP_CSR_PMPCFG0:`PMP_CSR_PMP_LAST]}) ||
                        (csr_num == `PMP_CSR_MSECCFG) ||
                        (csr_num == `PMP_CSR_MSECCFGH);

  always_comb begin
    sel = CSR_SEL_NONE;
    if (csr_num == `PMP_CSR_PMPCFG0) begin
      sel = CSR_SEL_PMPCFG;
    end else if (addr_off < 12'(`PMP_NUM_REGIONS)) begin
      sel = CSR_SEL_PMPADDR;
    end else if (csr_num == `PMP_CSR_MSECCFG) begin
      sel = CSR_SEL_MSECCFG;
    end
  end

  assign is_known = (sel != CSR_SEL_NONE);

  always_comb begin
    case ({1'b0, funct3[1:0]})
      `PMP_F3_CSRRS: cmd = CSR_CMD_SET;
      `PMP_F3_CSRRC: cmd = CSR_CMD_CLEAR;
      default:       cmd = CSR_CMD_WRITE;
    endcase
  end

  always_comb begin
    op_o.valid = csr_valid_i && is_csr_insn;
    op_o.sel   = sel;
    op_o.idx   = addr_off[$clog2(`PMP_NUM_REGIONS)-1:0];
    op_o.cmd   = cmd;
    // Set and clear with x0 only read
    op_o.wen   = (cmd == CSR_CMD_WRITE) || (rs1_addr != 5'd0);
    op_o.illegal = is_imm ||
                   (in_pmp_space && !is_known) ||
                   (in_pmp_space && (priv_i == PRIV_U));
    op_o.wdata.word = rs1_data_i;
  end

endmodule

//--- pmp_csr_file.sv
`timescale 1ns/1ps
`include "pmp_defines.svh"

module pmp_csr_file (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  pmp_pkg::csr_op_t    op_i,
  output pmp_pkg::pmp_state_t state_o,
  output logic                done_o,
  output logic [31:0]         rdata_o,
  output logic                illegal_o
);
  import pmp_pkg::*;

  pmp_cfg_t [`PMP_NUM_REGIONS-1:0]    cfg_q;
  pmp_cfg_t [`PMP_NUM_REGIONS-1:0]    cfg_d;
  logic [`PMP_NUM_REGIONS-1:0][31:0]  addr_q;
  logic [`PMP_NUM_REGIONS-1:0][31:0]  addr_d;
  logic                               mml_q;
  logic                               mml_d;
  logic                               rlb_q;
  logic                               rlb_d;
  logic [31:0]                        msec_word;
  logic [31:0]                        old_val;
  csr_wdata_u                         attempt;
  logic                               do_write;
  logic                               any_lock;
  logic [`PMP_NUM_REGIONS:0]          tor_lock;
  logic [`PMP_NUM_REGIONS-1:0]        addr_locked;
  logic                               done_q;
  logic                               illegal_q;
  logic [31:0]                        rdata_q;

  // Legal value of one cfg byte after a write attempt
  function automatic pmp_cfg_t rectify_cfg(pmp_cfg_t pre, pmp_cfg_t att, logic mml, logic rlb);
    pmp_cfg_t   res;
    logic [3:0] lrwx;
    res  = att;
    lrwx = {att.lock, att.read, att.write, att.exec};
    // Write without read is reserved unless MML
    if (({att.exec, att.write, att.read} inside {3'b010, 3'b110}) && !mml) begin
      res.exec  = pre.exec;
      res.write = pre.write;
      res.read  = pre.read;
    end
    if (pre.lock && !rlb) begin
      res = pre;
    end
    // No new locked executable entries under MML
    if (mml && !rlb && (lrwx inside {4'b1001, 4'b1010, 4'b1011, 4'b1101})) begin
      res = pre;
    end
    res.zero0 = 2'b00;
    return res;
  endfunction

  always_comb begin
    msec_word = '0;
    msec_word[`PMP_MSEC_MML_BIT] = mml_q;
    msec_word[`PMP_MSEC_RLB_BIT] = rlb_q;
  end

  always_comb begin
    case (op_i.sel)
      CSR_SEL_PMPCFG:  old_val = cfg_q;
      CSR_SEL_PMPADDR: old_val = addr_q[op_i.idx];
      CSR_SEL_MSECCFG: old_val = msec_word;
      default:         old_val = '0;
    endcase
  end

  always_comb begin
    case (op_i.cmd)
      CSR_CMD_SET:   attempt.word = old_val | op_i.wdata.word;
      CSR_CMD_CLEAR: attempt.word = old_val & ~op_i.wdata.word;
      default:       attempt.word = op_i.wdata.word;
    endcase
  end

  assign do_write = op_i.valid && op_i.wen && !op_i.illegal;

  // Lock state seen by the pmpaddr registers
  always_comb begin
    any_lock = 1'b0;
    tor_lock[`PMP_NUM_REGIONS] = 1'b0;
    for (int i = 0; i < `PMP_NUM_REGIONS; i++) begin
      any_lock    = any_lock | cfg_q[i].lock;
      tor_lock[i] = cfg_q[i].lock && (cfg_q[i].mode == PMP_MODE_TOR);
    end
    for (int i = 0; i < `PMP_NUM_REGIONS; i++) begin
      addr_locked[i] = !rlb_q && (cfg_q[i].lock || tor_lock[i+1]);
    end
  end

  always_comb begin
    cfg_d  = cfg_q;
    addr_d = addr_q;
    mml_d  = mml_q;
    rlb_d  = rlb_q;
    if (do_write) begin
      case (op_i.sel)
        CSR_SEL_PMPCFG: begin
          for (int i = 0; i < `PMP_NUM_REGIONS; i++) begin
            cfg_d[i] = rectify_cfg(cfg_q[i], attempt.cfg[i], mml_q, rlb_q);
          end
        end
        CSR_SEL_PMPADDR: begin
          if (!addr_locked[op_i.idx]) begin
            addr_d[op_i.idx] = attempt.word;
          end
        end
        CSR_SEL_MSECCFG: begin
          // MML is sticky until reset
          mml_d = mml_q | attempt.word[`PMP_MSEC_MML_BIT];
          rlb_d = (any_lock && !rlb_q) ? rlb_q : attempt.word[`PMP_MSEC_RLB_BIT];
        end
        default: begin
        end
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cfg_q     <= '0;
      addr_q    <= '0;
      mml_q     <= 1'b0;
      rlb_q     <= 1'b0;
      done_q    <= 1'b0;
      illegal_q <= 1'b0;
    end else begin
      cfg_q     <= cfg_d;
      addr_q    <= addr_d;
      mml_q     <= mml_d;
      rlb_q     <= rlb_d;
      done_q    <= op_i.valid;
      illegal_q <= op_i.valid && op_i.illegal;
    end
  end

  // Old value for the response
  always_ff @(posedge clk_i) begin
    rdata_q <= op_i.illegal ? '0 : old_val;
  end

  assign state_o.cfg  = cfg_q;
  assign state_o.addr = addr_q;
  assign state_o.mml  = mml_q;
  assign state_o.rlb  = rlb_q;

  assign done_o    = done_q;
  assign rdata_o   = rdata_q;
  assign illegal_o = illegal_q;

endmodule

//--- pmp_defines.svh
`ifndef PMP_DEFINES_SVH
`define PMP_DEFINES_SVH

// Number of implemented PMP regions
`define PMP_NUM_REGIONS 4

// CSR numbers
`define PMP_CSR_PMPCFG0   12'h3A0
`define PMP_CSR_PMPADDR0  12'h3B0
`define PMP_CSR_PMP_LAST  12'h3EF
`define PMP_CSR_MSECCFG   12'h747
`define PMP_CSR_MSECCFGH  12'h757

// SYSTEM opcode
`define PMP_OPC_SYSTEM 7'b1110011

// funct3 of the register CSR forms
`define PMP_F3_CSRRW 3'b001
`define PMP_F3_CSRRS 3'b010
`define PMP_F3_CSRRC 3'b011

// mseccfg bit positions
`define PMP_MSEC_MML_BIT 0
`define PMP_MSEC_RLB_BIT 2

`endif

//--- pmp_pkg.sv
`include "pmp_defines.svh"

package pmp_pkg;

  // Privilege modes seen by the unit
  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_M = 2'b11
  } priv_e;

  // Address matching mode of one region
  typedef enum logic [1:0] {
    PMP_MODE_OFF   = 2'b00,
    PMP_MODE_TOR   = 2'b01,
    PMP_MODE_NA4   = 2'b10,
    PMP_MODE_NAPOT = 2'b11
  } pmp_mode_e;

  // One pmpcfg byte
  typedef struct packed {
    logic      lock;
    logic [1:0] zero0;
    pmp_mode_e mode;
    logic      exec;
    logic      write;
    logic      read;
  } pmp_cfg_t;

  // CSR write word, either four cfg bytes or one plain word
  typedef union packed {
    pmp_cfg_t [3:0] cfg;
    logic [31:0]    word;
  } csr_wdata_u;

  typedef enum logic [1:0] {
    CSR_SEL_NONE    = 2'b00,
    CSR_SEL_PMPCFG  = 2'b01,
    CSR_SEL_PMPADDR = 2'b10,
    CSR_SEL_MSECCFG = 2'b11
  } csr_sel_e;

  typedef enum logic [1:0] {
    CSR_CMD_WRITE = 2'b00,
    CSR_CMD_SET   = 2'b01,
    CSR_CMD_CLEAR = 2'b10
  } csr_cmd_e;

  // Decoded CSR operation
  typedef struct packed {
    logic                                 valid;
    csr_sel_e                             sel;
    logic [$clog2(`PMP_NUM_REGIONS)-1:0]  idx;
    csr_cmd_e                             cmd;
    logic                                 wen;
    logic                                 illegal;
    csr_wdata_u                           wdata;
  } csr_op_t;

  typedef enum logic [1:0] {
    ACC_EXEC  = 2'b00,
    ACC_READ  = 2'b01,
    ACC_WRITE = 2'b10
  } acc_type_e;

  // One access to be checked
  typedef struct packed {
    logic        valid;
    logic [31:0] addr;
    acc_type_e   acc_type;
    priv_e       priv;
  } acc_req_t;

  // Register view handed to the access check
  typedef struct packed {
    pmp_cfg_t [`PMP_NUM_REGIONS-1:0]     cfg;
    logic [`PMP_NUM_REGIONS-1:0][31:0]   addr;
    logic                                mml;
    logic                                rlb;
  } pmp_state_t;

endpackage

//--- pmp_top.sv
`timescale 1ns/1ps

module pmp_top (
  input  logic                clk_i,
  input  logic                arst_n_i,
  // CSR instruction strobe
  input  logic                csr_valid_i,
  input  logic [31:0]         insn_i,
  input  logic [31:0]         rs1_data_i,
  input  pmp_pkg::priv_e      priv_i,
  // Access check strobe
  input  logic                acc_valid_i,
  input  logic [31:0]         acc_addr_i,
  input  pmp_pkg::acc_type_e  acc_type_i,
  input  pmp_pkg::priv_e      acc_priv_i,
  output logic                csr_done_o,
  output logic [31:0]         csr_rdata_o,
  output logic                csr_illegal_o,
  output logic                acc_done_o,
  output logic                acc_fault_o
);
  import pmp_pkg::*;

  csr_op_t    csr_op;
  pmp_state_t pmp_state;
  acc_req_t   acc_req;

  assign acc_req.valid    = acc_valid_i;
  assign acc_req.addr     = acc_addr_i;
  assign acc_req.acc_type = acc_type_i;
  assign acc_req.priv     = acc_priv_i;

  pmp_csr_decode pmp_csr_decode_i (
    .csr_valid_i (csr_valid_i),
    .insn_i      (insn_i),
    .rs1_data_i  (rs1_data_i),
    .priv_i      (priv_i),
    .op_o        (csr_op)
  );

  pmp_csr_file pmp_csr_file_i (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .op_i      (csr_op),
    .state_o   (pmp_state),
    .done_o    (csr_done_o),
    .rdata_o   (csr_rdata_o),
    .illegal_o (csr_illegal_o)
  );

  pmp_check pmp_check_i (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .req_i    (acc_req),
    .state_i  (pmp_state),
    .done_o   (acc_done_o),
    .fault_o  (acc_fault_o)
  );

endmodule

//--- tb_pmp_vectors.svh
// CSR rows give instruction, rs1 value, mode, expected rdata and expected illegal
// Access rows give address, access type, mode and expected fault
task automatic load_vectors();
  // U-mode and immediate forms are illegal and write nothing
  csr_row(csr_insn(12'h3B1, 5'd2, `PMP_F3_CSRRW), 32'h0000_1234, PRIV_U, 32'h0, 1'b1);
  csr_row(csr_insn(12'h3B1, 5'd0, `PMP_F3_CSRRS), 32'hFFFF_FFFF, PRIV_M, 32'h0, 1'b0);
  // CSRRWI
  csr_row(csr_insn(12'h3B1, 5'd7, 3'b101), 32'h0000_0ABC, PRIV_M, 32'h0, 1'b1);
  // pmpaddr0 to pmpaddr3 write and read back
  csr_row(csr_insn(12'h3B0, 5'd2, `PMP_F3_CSRRW), 32'h0000_0100, PRIV_M, 32'h0, 1'b0);
  csr_row(csr_insn(12'h3B1, 5'd2, `PMP_F3_CSRRW), 32'h0000_0200, PRIV_M, 32'h0, 1'b0);
  csr_row(csr_insn(12'h3B2, 5'd2, `PMP_F3_CSRRW), 32'h0000_11FF, PRIV_M, 32'h0, 1'b0);
  csr_row(csr_insn(12'h3B3, 5'd2, `PMP_F3_CSRRW), 32'h0000_3000, PRIV_M, 32'h0, 1'b0);
  csr_row(csr_insn(12'h3B0, 5'd0, `PMP_F3_CSRRS), 32'hFFFF_FFFF, PRIV_M, 32'h100, 1'b0);
  csr_row(csr_insn(12'h3B1, 5'd0, `PMP_F3_CSRRS), 32'hFFFF_FFFF, PRIV_M, 32'h200, 1'b0);
  csr_row(csr_insn(12'h3B2, 5'd0, `PMP_F3_CSRRS), 32'hFFFF_FFFF, PRIV_M, 32'h11FF, 1'b0);
  csr_row(csr_insn(12'h3B3, 5'd0, `PMP_F3_CSRRS), 32'hFFFF_FFFF, PRIV_M, 32'h3000, 1'b0);
  // pmpcfg0 set and clear
  csr_row(csr_insn(12'h3A0, 5'd2, `PMP_F3_CSRRS), 32'h0000_0900, PRIV_M, 32'h0, 1'b0);
  csr_row(csr_insn(12'h3A0, 5'd2, `PMP_F3_CSRRS), 32'h0000_0003, PRIV_M, 32'h0900, 1'b0);
  csr_row(csr_insn(12'h3A0, 5'd2, `PMP_F3_CSRRC), 32'h0000_0003, PRIV_M, 32'h0903, 1'b0);
  csr_row(csr_insn(12'h3A0, 5'd2, `PMP_F3_CSRRW), 32'h0000_0903, PRIV_M, 32'h0900, 1'b0);
  // RWX 010 keeps old RWX and reserved bits drop
  csr_row(csr_insn(12'h3A0, 5'd2, `PMP_F3_CSRRW), 32'h0000_0902, PRIV_M, 32'h0903, 1'b0);
  csr_row(csr_insn(12'h3A0, 5'd2, `PMP_F3_CSRRW), 32'h0060_0903, PRIV_M, 32'h0903, 1'b0);
  // Locked exec byte refused under MML until RLB is set
  csr_row(csr_insn(12'h747, 5'd2, `PMP_F3_CSRRW), 32'h0000_0001, PRIV_M, 32'h0, 1'b0);
  csr_row(csr_insn(12'h3A0, 5'd2, `PMP_F3_CSRRW), 32'h8400_0903, PRIV_M, 32'h0903, 1'b0);
  csr_row(csr_insn(12'h747, 5'd2, `PMP_F3_CSRRS), 32'h0000_0004, PRIV_M, 32'h1, 1'b0);
  csr_row(csr_insn(12'h3A0, 5'd2, `PMP_F3_CSRRW), 32'h8400_0903, PRIV_M, 32'h0903, 1'b0);
  csr_row(csr_insn(12'h747, 5'd2, `PMP_F3_CSRRC), 32'h0000_0004, PRIV_M, 32'h5, 1'b0);
  // Lock entry 1 as TOR and entry 2 as NAPOT
  csr_row(csr_insn(12'h3A0, 5'd2, `PMP_F3_CSRRW), 32'h8499_8903, PRIV_M, 32'h8400_0903, 1'b0);
  csr_row(csr_insn(12'h3A0, 5'd2, `PMP_F3_CSRRW), 32'h0000_0B03, PRIV_M, 32'h8499_8903, 1'b0);
  csr_row(csr_insn(12'h3B1, 5'd2, `PMP_F3_CSRRW), 32'h0000_0FFF, PRIV_M, 32'h200, 1'b0);
  csr_row(csr_insn(12'h3B0, 5'd2, `PMP_F3_CSRRW), 32'h0000_0000, PRIV_M, 32'h100, 1'b0);
  csr_row(csr_insn(12'h3B1, 5'd0, `PMP_F3_CSRRS), 32'hFFFF_FFFF, PRIV_M, 32'h200, 1'b0);
  csr_row(csr_insn(12'h3B0, 5'd0, `PMP_F3_CSRRS), 32'hFFFF_FFFF, PRIV_M, 32'h100, 1'b0);
  csr_row(csr_insn(12'h3A0, 5'd0, `PMP_F3_CSRRS), 32'h0, PRIV_M, 32'h8499_8903, 1'b0);
  // RLB stays clear while a byte is locked
  csr_row(csr_insn(12'h747, 5'd2, `PMP_F3_CSRRS), 32'h0000_0004, PRIV_M, 32'h1, 1'b0);
  csr_row(csr_insn(12'h747, 5'd0, `PMP_F3_CSRRS), 32'h0, PRIV_M, 32'h1, 1'b0);
  // TOR region 1 covers bytes 0x400 to 0x7FF
  // NAPOT region 2 covers bytes 0x4000 to 0x4FFF
  access_row(32'h0000_0400, ACC_READ, PRIV_U, 1'b0);
  access_row(32'h0000_0400, ACC_WRITE, PRIV_U, 1'b1);
  access_row(32'h0000_0800, ACC_READ, PRIV_U, 1'b1);
  access_row(32'h0000_2000, ACC_READ, PRIV_U, 1'b1);
  access_row(32'h0000_2000, ACC_READ, PRIV_M, 1'b0);
  access_row(32'h0000_4800, ACC_EXEC, PRIV_M, 1'b1);
  access_row(32'h0000_4800, ACC_READ, PRIV_M, 1'b0);
endtask

//--- tb_pmp_top.sv
`timescale 1ns/1ps
`include "pmp_defines.svh"

module tb_pmp_top;
  import pmp_pkg::*;

  localparam int RESET_CYCLES = 4;
  localparam int DONE_TIMEOUT = 8;

  // One table row for a CSR instruction or an access check
  typedef struct packed {
    logic        is_csr;
    logic [31:0] word;
    logic [31:0] rs1;
    acc_type_e   acc_type;
    priv_e       priv;
    logic [31:0] exp_rdata;
    logic        exp_flag;
  } vector_t;

  logic        clk;
  logic        arst_n;
  logic        csr_valid;
  logic [31:0] insn;
  logic [31:0] rs1_data;
  priv_e       priv;
  logic        acc_valid;
  logic [31:0] acc_addr;
  acc_type_e   acc_type;
  priv_e       acc_priv;
  logic        csr_done;
  logic [31:0] csr_rdata;
  logic        csr_illegal;
  logic        acc_done;
  logic        acc_fault;

  vector_t vectors[$];

  always begin
    #5 clk = ~clk;
  end

  pmp_top pmp_top_i (
    .clk_i         (clk),
    .arst_n_i      (arst_n),
    .csr_valid_i   (csr_valid),
    .insn_i        (insn),
    .rs1_data_i    (rs1_data),
    .priv_i        (priv),
    .acc_valid_i   (acc_valid),
    .acc_addr_i    (acc_addr),
    .acc_type_i    (acc_type),
    .acc_priv_i    (acc_priv),
    .csr_done_o    (csr_done),
    .csr_rdata_o   (csr_rdata),
    .csr_illegal_o (csr_illegal),
    .acc_done_o    (acc_done),
    .acc_fault_o   (acc_fault)
  );

  // SYSTEM instruction word with rd fixed to x1
  function automatic logic [31:0] csr_insn(input logic [11:0] csr, input logic [4:0] rs1,
                                           input logic [2:0] f3);
    return {csr, rs1, f3, 5'd1, `PMP_OPC_SYSTEM};
  endfunction

  task automatic csr_row(input logic [31:0] insn_word, input logic [31:0] rs1_val,
                         input priv_e mode, input logic [31:0] exp_rdata,
                         input logic exp_illegal);
    vector_t v;
    v           = '0;
    v.is_csr    = 1'b1;
    v.word      = insn_word;
    v.rs1       = rs1_val;
    v.priv      = mode;
    v.exp_rdata = exp_rdata;
    v.exp_flag  = exp_illegal;
    vectors.push_back(v);
  endtask

  task automatic access_row(input logic [31:0] addr, input acc_type_e kind, input priv_e mode,
                            input logic exp_fault);
    vector_t v;
    v          = '0;
    v.word     = addr;
    v.acc_type = kind;
    v.priv     = mode;
    v.exp_flag = exp_fault;
    vectors.push_back(v);
  endtask

  `include "tb_pmp_vectors.svh"

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("Fail: time %0t, %s expected %h, got %h", $time, name, expected, actual);
      $display("TEST FAIL");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  // Strobe for one cycle and wait for the matching done pulse
  task automatic apply_row(input vector_t v);
    int   waited;
    logic done_seen;
    @(negedge clk);
    // Done pulse of the previous row has dropped
    check_value("csr_done_o", 32'd0, {31'd0, csr_done});
    check_value("acc_done_o", 32'd0, {31'd0, acc_done});
    if (v.is_csr) begin
      insn      = v.word;
      rs1_data  = v.rs1;
      priv      = v.priv;
      csr_valid = 1'b1;
    end else begin
      acc_addr  = v.word;
      acc_type  = v.acc_type;
      acc_priv  = v.priv;
      acc_valid = 1'b1;
    end
    @(negedge clk);
    csr_valid = 1'b0;
    acc_valid = 1'b0;
    waited    = 1;
    done_seen = v.is_csr ? csr_done : acc_done;
    while (!done_seen && waited < DONE_TIMEOUT) begin
      @(negedge clk);
      waited++;
      done_seen = v.is_csr ? csr_done : acc_done;
    end
    if (!done_seen) begin
      $display("Timeout: %s did not rise after the strobe",
               v.is_csr ? "csr_done_o" : "acc_done_o");
      $display("TEST FAIL");
      $fatal(1, "Missing done strobe");
    end
    // Done is due one cycle after the strobe
    check_value(v.is_csr ? "csr_done_o latency" : "acc_done_o latency", 32'd1, waited);
    if (v.is_csr) begin
      check_value("csr_illegal_o", {31'd0, v.exp_flag}, {31'd0, csr_illegal});
      // Read data only defined for legal instructions
      if (!v.exp_flag) begin
        check_value("csr_rdata_o", v.exp_rdata, csr_rdata);
      end
    end else begin
      check_value("acc_fault_o", {31'd0, v.exp_flag}, {31'd0, acc_fault});
    end
  endtask

  initial begin
    clk       = 1'b0;
    arst_n    = 1'b0;
    csr_valid = 1'b0;
    insn      = '0;
    rs1_data  = '0;
    priv      = PRIV_M;
    acc_valid = 1'b0;
    acc_addr  = '0;
    acc_type  = ACC_READ;
    acc_priv  = PRIV_M;
    load_vectors();
    repeat (RESET_CYCLES) @(negedge clk);
    arst_n = 1'b1;
    check_value("csr_done_o", 32'd0, {31'd0, csr_done});
    check_value("acc_done_o", 32'd0, {31'd0, acc_done});
    check_value("csr_illegal_o", 32'd0, {31'd0, csr_illegal});
    check_value("acc_fault_o", 32'd0, {31'd0, acc_fault});
    foreach (vectors[i]) begin
      apply_row(vectors[i]);
    end
    $display("TEST PASS");
    $finish;
  end

endmodule
